// File: hdl/cipherDecode.sv
// APB slave with register decode, letter decoding and result occupancy tracking
`timescale 1ns/1ps
`include "cipher_consts.svh"

module cipherDecode (
    input  logic                   load,
    input  logic                   arstN,
    input  cipher_pkg::apbReq_t    apbReq,
    output cipher_pkg::apbRsp_t    apbRsp,
    input  cipher_pkg::asciiChar_t headChar,
    output logic                   pop,
    output cipher_pkg::cipherCmd_t cmd
);

    logic                   access;
    logic                   isCtrl;
    logic                   isData;
    logic                   isResult;
    logic                   isStatus;
    logic                   isKey;
    logic [31:0]            keyOffset;
    cipher_pkg::asciiChar_t wrByte;
    logic                   byteIsLetter;
    cipher_pkg::letterIdx_t byteIdx;
    cipher_pkg::keyLen_t    wrKeyLen;
    cipher_pkg::keyLen_t    normKeyLen;
    logic                   ctrlDecrypt;
    cipher_pkg::keyLen_t    ctrlKeyLen;
    logic [2:0]             occupancy;
    logic [2:0]             readyCount;
    logic                   queueFull;
    logic                   headAvail;
    logic                   wrDone;
    logic                   dataAccepted;
    cipher_pkg::cipherCmd_t cmdNext;

    assign access = apbReq.psel && apbReq.penable;

    // Address decode
    assign isCtrl = apbReq.paddr == `ADDR_CTRL;
    assign isData = apbReq.paddr == `ADDR_DATA;
    assign isResult = apbReq.paddr == `ADDR_RESULT;
    assign isStatus = apbReq.paddr == `ADDR_STATUS;
    assign keyOffset = apbReq.paddr - `ADDR_KEY_BASE;
    assign isKey = (apbReq.paddr >= `ADDR_KEY_BASE) && (keyOffset[1:0] == 2'b00)
                   && (keyOffset[31:2] < `KEY_SLOTS);

    // Uppercase letters become an index, everything else stays raw
    assign wrByte = apbReq.pwdata[7:0];
    assign byteIsLetter = (wrByte >= "A") && (wrByte <= "Z");
    assign byteIdx = byteIsLetter ? cipher_pkg::letterIdx_t'(wrByte - "A") : '0;

    assign wrKeyLen = apbReq.pwdata[`CTRL_KEYLEN_MSB:`CTRL_KEYLEN_LSB];
    assign normKeyLen = (wrKeyLen == '0 || wrKeyLen > `KEY_SLOTS)
                        ? cipher_pkg::keyLen_t'(`KEY_SLOTS) : wrKeyLen;

    // A char still in the command register cannot be read yet
    assign readyCount = occupancy - {2'b00, cmd.kind == cipher_pkg::cmdChar};
    assign headAvail = readyCount != 3'd0;
    assign queueFull = occupancy == 3'(`RESULT_DEPTH);

    always_comb begin
        apbRsp.pready = access && !(apbReq.pwrite && isData && queueFull);
        apbRsp.pslverr = 1'b0;
        apbRsp.prdata = '0;
        if (access) begin
            if (!(isCtrl || isData || isResult || isStatus || isKey)) begin
                apbRsp.pslverr = 1'b1;
            end else if (!apbReq.pwrite && isResult && !headAvail) begin
                apbRsp.pslverr = 1'b1;
            end
        end
        if (access && !apbReq.pwrite) begin
            if (isResult && headAvail) begin
                apbRsp.prdata[7:0] = headChar;
            end else if (isStatus) begin
                apbRsp.prdata[2:0] = occupancy;
            end else if (isCtrl) begin
                apbRsp.prdata[`CTRL_KEYLEN_MSB:`CTRL_KEYLEN_LSB] = ctrlKeyLen;
                apbRsp.prdata[`CTRL_DECRYPT_BIT] = ctrlDecrypt;
            end
        end
    end

    assign pop = access && !apbReq.pwrite && isResult && headAvail;
    assign wrDone = access && apbReq.pwrite && apbRsp.pready;
    assign dataAccepted = wrDone && isData;

    // Queued plus in-flight results
    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + {2'b00, dataAccepted} - {2'b00, pop};
        end
    end

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            ctrlDecrypt <= 1'b0;
            ctrlKeyLen <= cipher_pkg::keyLen_t'(`KEY_SLOTS);
        end else if (wrDone && isCtrl) begin
            ctrlDecrypt <= apbReq.pwdata[`CTRL_DECRYPT_BIT];
            ctrlKeyLen <= normKeyLen;
        end
    end

    always_comb begin
        cmdNext = '0;
        cmdNext.kind = cipher_pkg::cmdNone;
        cmdNext.decrypt = ctrlDecrypt;
        cmdNext.keyLen = ctrlKeyLen;
        if (wrDone) begin
            if (isData) begin
                cmdNext.kind = cipher_pkg::cmdChar;
                cmdNext.isLetter = byteIsLetter;
                cmdNext.index = byteIdx;
                cmdNext.raw = wrByte;
            end else if (isKey) begin
                cmdNext.kind = cipher_pkg::cmdKeyWrite;
                cmdNext.keySlot = keyOffset[5:2];
                cmdNext.keyIdx = byteIdx;
            end else if (isCtrl) begin
                cmdNext.kind = cipher_pkg::cmdRestart;
                cmdNext.decrypt = apbReq.pwdata[`CTRL_DECRYPT_BIT];
                cmdNext.keyLen = normKeyLen;
            end
        end
    end

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            cmd <= '0;
        end else begin
            cmd <= cmdNext;
        end
    end

endmodule

// File: hdl/cipher_pkg.sv
// Character, command, result and APB types for the Vigenere cipher
package cipher_pkg;

    typedef logic [7:0] asciiChar_t;
    typedef logic [4:0] letterIdx_t;
    typedef logic [3:0] keyLen_t;

    typedef enum logic [1:0] {
        cmdNone,
        cmdChar,
        cmdKeyWrite,
        cmdRestart
    } cmdKind_e;

    typedef struct packed {
        cmdKind_e   kind;
        logic       decrypt;
        logic       isLetter;
        letterIdx_t index;
        asciiChar_t raw;
        logic [3:0] keySlot;
        keyLen_t    keyLen;
        letterIdx_t keyIdx;
        logic [2:0] spare;
    } cipherCmd_t;

    typedef struct packed {
        logic       valid;
        logic       isLetter;
        letterIdx_t index;
        asciiChar_t raw;
    } cipherOut_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

endpackage

// File: hdl/keyShift.sv
// Key store, key position counter and modular letter shift
`timescale 1ns/1ps
`include "cipher_consts.svh"

module keyShift (
    input  logic                   load,
    input  logic                   arstN,
    input  cipher_pkg::cipherCmd_t cmd,
    output cipher_pkg::cipherOut_t result
);

    cipher_pkg::letterIdx_t keys [`KEY_SLOTS];
    cipher_pkg::keyLen_t    keyLen;
    cipher_pkg::keyLen_t    keyPos;
    cipher_pkg::letterIdx_t curKey;
    logic [5:0]             sum;
    cipher_pkg::letterIdx_t shifted;

    assign curKey = keys[keyPos];

    // Add or subtract the key letter modulo the alphabet
    always_comb begin
        if (cmd.decrypt) begin
            sum = {1'b0, cmd.index} + 6'(`ALPHABET_SIZE) - {1'b0, curKey};
        end else begin
            sum = {1'b0, cmd.index} + {1'b0, curKey};
        end
        if (sum >= 6'(`ALPHABET_SIZE)) begin
            shifted = cipher_pkg::letterIdx_t'(sum - 6'(`ALPHABET_SIZE));
        end else begin
            shifted = cipher_pkg::letterIdx_t'(sum);
        end
    end

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `KEY_SLOTS; i++) begin
                keys[i] <= '0;
            end
            keyLen <= cipher_pkg::keyLen_t'(`KEY_SLOTS);
            keyPos <= '0;
        end else begin
            case (cmd.kind)
                cipher_pkg::cmdKeyWrite: begin
                    if (cmd.keySlot < `KEY_SLOTS) begin
                        keys[cmd.keySlot] <= cmd.keyIdx;
                    end
                end
                cipher_pkg::cmdRestart: begin
                    keyLen <= cmd.keyLen;
                    keyPos <= '0;
                end
                cipher_pkg::cmdChar: begin
                    // Non-letters keep the key where it is
                    if (cmd.isLetter) begin
                        keyPos <= (keyPos == keyLen - 4'd1) ? '0 : keyPos + 4'd1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
        end else begin
            result.valid <= cmd.kind == cipher_pkg::cmdChar;
            result.isLetter <= cmd.isLetter;
            result.index <= cmd.isLetter ? shifted : cmd.index;
            result.raw <= cmd.raw;
        end
    end

endmodule

// File: hdl/resultQueue.sv
// Index to ASCII encoder and result FIFO with read-through head
`timescale 1ns/1ps
`include "cipher_consts.svh"

module resultQueue (
    input  logic                   load,
    input  logic                   arstN,
    input  cipher_pkg::cipherOut_t result,
    input  logic                   pop,
    output cipher_pkg::asciiChar_t headChar
);

    localparam int PTR_W = $clog2(`RESULT_DEPTH);

    cipher_pkg::asciiChar_t mem [`RESULT_DEPTH];
    logic [PTR_W-1:0]       wrPtr;
    logic [PTR_W-1:0]       rdPtr;
    logic [PTR_W:0]         count;
    cipher_pkg::asciiChar_t inChar;
    logic                   empty;
    logic                   bypass;
    logic                   doPush;
    logic                   doPop;

    assign inChar = result.isLetter ? "A" + {3'b000, result.index} : result.raw;

    // Empty queue hands the arriving result straight to the reader
    assign empty = count == '0;
    assign bypass = empty && pop;
    assign doPush = result.valid && !bypass;
    assign doPop = pop && !empty;
    assign headChar = empty ? inChar : mem[rdPtr];

    always_ff @(posedge load) begin
        if (doPush) begin
            mem[wrPtr] <= inChar;
        end
    end

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PTR_W'(`RESULT_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_W'(`RESULT_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(doPush) - (PTR_W + 1)'(doPop);
        end
    end

endmodule

// File: hdl/vigenereCipher.sv
// Top level of the Vigenere cipher with APB front end
`timescale 1ns/1ps

module vigenereCipher (
    input  logic                load,
    input  logic                arstN,
    input  cipher_pkg::apbReq_t apbReq,
    output cipher_pkg::apbRsp_t apbRsp
);

    cipher_pkg::cipherCmd_t cmd;
    cipher_pkg::cipherOut_t result;
    cipher_pkg::asciiChar_t headChar;
    logic                   pop;

    cipherDecode decodeStage (
        .load     (load),
        .arstN    (arstN),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .headChar (headChar),
        .pop      (pop),
        .cmd      (cmd)
    );

    // Key letter applied here
    keyShift shiftStage (
        .load   (load),
        .arstN  (arstN),
        .cmd    (cmd),
        .result (result)
    );

    resultQueue queueStage (
        .load     (load),
        .arstN    (arstN),
        .result   (result),
        .pop      (pop),
        .headChar (headChar)
    );

endmodule

// File: include/cipher_consts.svh
// Alphabet, key, queue and register map constants for the Vigenere cipher
`ifndef CIPHER_CONSTS_SVH
`define CIPHER_CONSTS_SVH

`define ALPHABET_SIZE 26
`define KEY_SLOTS 10
`define RESULT_DEPTH 4

// Register map
`define ADDR_CTRL 32'h0000_0000
`define ADDR_DATA 32'h0000_0004
`define ADDR_RESULT 32'h0000_0008
`define ADDR_STATUS 32'h0000_000C
`define ADDR_KEY_BASE 32'h0000_0010

// Control register fields
`define CTRL_DECRYPT_BIT 0
`define CTRL_KEYLEN_LSB 4
`define CTRL_KEYLEN_MSB 7

`endif

// File: tb.f
+incdir+include
hdl/cipher_pkg.sv
hdl/cipherDecode.sv
hdl/keyShift.sv
hdl/resultQueue.sv
hdl/vigenereCipher.sv
verification/vigenere_properties.sv
verification/tb_vigenere.sv

// File: verification/tb_vigenere.sv
// Testbench for the Vigenere cipher, driven from a stimulus file over APB
`timescale 1ns/1ps
`include "cipher_consts.svh"

module tb_vigenere;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = 50;
    localparam int STALL_CYCLES = 5;
    localparam int MAX_WORDS = 256;

    logic                load;
    logic                arstN;
    cipher_pkg::apbReq_t apbReq;
    cipher_pkg::apbRsp_t apbRsp;
    logic [31:0]         stim [MAX_WORDS];

    vigenereCipher dut_i (
        .load   (load),
        .arstN  (arstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    always #(CLK_PERIOD / 2) load = ~load;

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // Bound assertions count their failures
    always @(dut_i.propsCheck.failCount) begin
        if (dut_i.propsCheck.failCount != 0) begin
            reportFailure("An APB response assertion failed");
        end
    end

    task automatic checkChar(input cipher_pkg::asciiChar_t expected,
                             input cipher_pkg::asciiChar_t actual);
        if (actual !== expected) begin
            reportFailure($sformatf("Mismatch prdata: expected 0x%h, got 0x%h", expected, actual));
        end
    endtask

    task automatic checkStatus(input cipher_pkg::keyLen_t expected,
                               input cipher_pkg::keyLen_t actual);
        if (actual !== expected) begin
            reportFailure($sformatf("Mismatch occupancy: expected 0x%h, got 0x%h", expected, actual));
        end
    endtask

    task automatic checkErr(input logic expected, input logic actual);
        if (actual !== expected) begin
            reportFailure($sformatf("Mismatch pslverr: expected 0x%h, got 0x%h", expected, actual));
        end
    endtask

    // Setup and access phases, then wait until just short of the rising edge
    task automatic startTransfer(input logic isWrite, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        @(negedge load);
        apbReq.psel = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite = isWrite;
        apbReq.paddr = addr;
        apbReq.pwdata = wdata;
        @(negedge load);
        apbReq.penable = 1'b1;
        #(CLK_PERIOD / 2 - 2);
    endtask

    task automatic apbTransfer(input logic isWrite, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        int waited;
        startTransfer(isWrite, addr, wdata);
        waited = 0;
        while (apbRsp.pready !== 1'b1) begin
            if (waited == TIMEOUT_CYCLES) begin
                reportFailure($sformatf("APB transfer to address 0x%h timed out", addr));
            end
            waited++;
            #(CLK_PERIOD);
        end
        rdata = apbRsp.prdata;
        err = apbRsp.pslverr;
        @(posedge load);
    endtask

    // Full queue must hold the write off, then the bus lets go of it
    task automatic stallWrite(input logic [31:0] addr, input logic [31:0] wdata);
        startTransfer(1'b1, addr, wdata);
        for (int i = 0; i < STALL_CYCLES; i++) begin
            if (apbRsp.pready !== 1'b0) begin
                reportFailure("DATA write to a full queue was not held off");
            end
            #(CLK_PERIOD);
        end
        @(negedge load);
        apbReq.psel = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    initial begin
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] extra;
        logic [31:0] rdata;
        logic        err;
        int          pos;
        load = 1'b0;
        arstN = 1'b0;
        apbReq = '0;
        for (int i = 0; i < MAX_WORDS; i++) begin
            stim[i] = '0;
        end
        $readmemh("verification/vigenere_stimulus.txt", stim);
        repeat (RESET_CYCLES) @(posedge load);
        @(negedge load);
        arstN = 1'b1;
        pos = 0;
        while (stim[pos] !== 32'd0) begin
            if (pos + 4 > MAX_WORDS) begin
                reportFailure("Stimulus file has no end marker");
            end
            kind = stim[pos];
            addr = stim[pos + 1];
            data = stim[pos + 2];
            extra = stim[pos + 3];
            case (kind)
                32'd1: begin
                    apbTransfer(1'b1, addr, data, rdata, err);
                    checkErr(1'b0, err);
                end
                32'd2: begin
                    for (int i = 0; i < extra; i++) begin
                        apbTransfer(1'b1, `ADDR_DATA, {24'h0, data[31 - 8 * i -: 8]}, rdata, err);
                        checkErr(1'b0, err);
                    end
                end
                32'd3: begin
                    for (int i = 0; i < extra; i++) begin
                        apbTransfer(1'b0, `ADDR_RESULT, '0, rdata, err);
                        checkErr(1'b0, err);
                        checkChar(data[31 - 8 * i -: 8], rdata[7:0]);
                    end
                end
                32'd4: begin
                    apbTransfer(1'b0, `ADDR_STATUS, '0, rdata, err);
                    checkErr(extra[0], err);
                    checkStatus(data[3:0], rdata[3:0]);
                end
                32'd5: begin
                    apbTransfer(1'b0, addr, '0, rdata, err);
                    checkErr(extra[0], err);
                    checkChar(data[7:0], rdata[7:0]);
                end
                32'd6: stallWrite(addr, data);
                default: reportFailure($sformatf("Unknown stimulus kind %0d", kind));
            endcase
            pos = pos + 4;
        end
        @(negedge load);
        apbReq = '0;
        repeat (2) @(posedge load);
        @(negedge load);
        if (dut_i.propsCheck.failCount == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            reportFailure("An APB response assertion failed");
        end
    end

endmodule

// File: verification/vigenere_properties.sv
// Concurrent APB response checks bound to the Vigenere cipher top level
`timescale 1ns/1ps
`include "cipher_consts.svh"

module vigenere_properties (
    input logic                load,
    input logic                arstN,
    input cipher_pkg::apbReq_t apbReq,
    input cipher_pkg::apbRsp_t apbRsp
);

    logic access;
    logic dataWrite;
    // Number of failed checks so far
    int   failCount;

    initial begin
        failCount = 0;
    end

    assign access = apbReq.psel && apbReq.penable;
    assign dataWrite = apbReq.pwrite && (apbReq.paddr == `ADDR_DATA);

    errNeedsReady: assert property (@(posedge load) disable iff (!arstN)
        apbRsp.pslverr |-> apbRsp.pready)
        else begin
            failCount++;
            $error("pslverr high without pready");
        end

    // Only a full queue may stretch a transfer
    waitOnlyOnData: assert property (@(posedge load) disable iff (!arstN)
        (access && !apbRsp.pready) |-> dataWrite)
        else begin
            failCount++;
            $error("Wait state outside a DATA write access");
        end

    readyOnlyInAccess: assert property (@(posedge load) disable iff (!arstN)
        !access |-> !apbRsp.pready)
        else begin
            failCount++;
            $error("pready high outside an access phase");
        end

endmodule

bind vigenereCipher vigenere_properties propsCheck (
    .load   (load),
    .arstN  (arstN),
    .apbReq (apbReq),
    .apbRsp (apbRsp)
);

// File: verification/vigenere_stimulus.txt
// kind addr data extra: 1 write, 2 send chars, 3 receive chars, 4 STATUS read, 5 error read
// kind 6 held DATA write, 0 end; chars are packed first byte high, extra is count or pslverr
5 00000008 00000000 1
5 00000040 00000000 1
1 00000000 00000010 0
1 00000010 00000044 0
2 00000000 58595A00 3
3 00000000 41424300 3
1 00000000 00000011 0
2 00000000 41424300 3
3 00000000 58595A00 3
1 00000000 00000050 0
1 00000010 0000004C 0
1 00000014 00000045 0
1 00000018 0000004D 0
1 0000001C 0000004F 0
1 00000020 0000004E 0
2 00000000 41545441 4
3 00000000 4C58464F 4
2 00000000 434B4154 4
3 00000000 50564546 4
2 00000000 4441574E 4
3 00000000 524E4852 4
2 00000000 41203142 4
3 00000000 4D203150 4
2 00000000 41410000 2
1 00000000 00000050 0
2 00000000 41410000 2
3 00000000 4E4C4C45 4
2 00000000 41414141 4
4 0000000C 00000004 0
6 00000004 00000041 0
3 00000000 4D000000 1
2 00000000 41000000 1
3 00000000 4F4E4C45 4
4 0000000C 00000000 0
0 00000000 00000000 0
